// File: common/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// Instruction halfword
`define INSTR_WIDTH 16

// Decoded instruction ID, up to 128 codes
`define ID_WIDTH 7

// Register index, bit 3 selects the high bank
`define REG_WIDTH 4

// Widest immediate carried to execute
`define OFFSET_WIDTH 12

// Bit 4 set means not a branch
`define COND_WIDTH 5

`endif

// File: common/isaPkg.sv
`default_nettype none

`include "decode_defs.svh"

package isaPkg;

  // Register-operand view, also used for 5-bit immediate forms
  typedef struct packed {
    logic [3:0] opcode;
    logic       op;
    logic [4:0] imm5;   // Also holds regB and sub-opcodes
    logic [2:0] regA;
    logic [2:0] regD;
  } regFormatT;

  // 8-bit immediate view
  typedef struct packed {
    logic [3:0] opcode;
    logic       op;
    logic [2:0] regIdx; // Register or sub-opcode in bits 10..8
    logic [7:0] imm8;
  } immFormatT;

  typedef union packed {
    regFormatT regFmt;
    immFormatT immFmt;
  } instrWordT;

  localparam logic [`ID_WIDTH-1:0] idHlt         = 7'h4a;
  localparam logic [`ID_WIDTH-1:0] idNop         = 7'h4b;
  localparam logic [`ID_WIDTH-1:0] idBiosJump    = 7'd77;
  localparam logic [`ID_WIDTH-1:0] idResetMarker = 7'd100;

  // Undefined encodings, one per decode group
  localparam logic [`ID_WIDTH-1:0] idUndefMisc   = 7'h7a; // Opcode 11
  localparam logic [`ID_WIDTH-1:0] idUndefAlu    = 7'h7d; // Opcode 4
  localparam logic [`ID_WIDTH-1:0] idUndefAddSub = 7'h7e; // Opcode 1
  localparam logic [`ID_WIDTH-1:0] idUndefOpcode = 7'h7f; // Opcode 15

  localparam logic [`COND_WIDTH-1:0] condAlways   = 5'd14;
  localparam logic [`COND_WIDTH-1:0] condBiosJump = 5'd15; // Also always
  localparam logic [`COND_WIDTH-1:0] condNone     = 5'd31;

endpackage

`default_nettype wire

// File: common/decodePkg.sv
`default_nettype none

`include "decode_defs.svh"

package decodePkg;

  // Output of the combinational decoder
  typedef struct packed {
    logic [`ID_WIDTH-1:0]     id;
    logic [`REG_WIDTH-1:0]    regD;
    logic [`REG_WIDTH-1:0]    regA;
    logic [`REG_WIDTH-1:0]    regB;
    logic [`OFFSET_WIDTH-1:0] offset;
    logic [`COND_WIDTH-1:0]   branchCond;
  } decodedT;

  // NZCV status flags
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // Registered bundle handed to execute
  typedef struct packed {
    decodedT decoded;
    logic    branchTaken;
  } issueT;

endpackage

`default_nettype wire

// File: decoder/instructionDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module instructionDecoder (
  input  wire isaPkg::instrWordT instr,
  input  wire                    isBios,
  output decodePkg::decodedT     decoded
);

  import isaPkg::*;

  logic [1:0] funct1; // Bits 7..6
  logic [3:0] funct2; // Bits 11..8

  assign funct1 = instr.immFmt.imm8[7:6];
  assign funct2 = {instr.immFmt.op, instr.immFmt.regIdx};

  function automatic logic [`REG_WIDTH-1:0] lowReg(input logic [2:0] r);
    return {1'b0, r};
  endfunction

  function automatic logic [`OFFSET_WIDTH-1:0] zext5(input logic [4:0] v);
    return {{(`OFFSET_WIDTH-5){1'b0}}, v};
  endfunction

  function automatic logic [`OFFSET_WIDTH-1:0] zext8(input logic [7:0] v);
    return {{(`OFFSET_WIDTH-8){1'b0}}, v};
  endfunction

  always_comb begin
    decoded            = '0;
    decoded.branchCond = condNone;

    case (instr.regFmt.opcode)
      4'd0: begin // Shift by immediate
        decoded.id     = instr.regFmt.op ? 7'h02 : 7'h01;
        decoded.offset = zext5(instr.regFmt.imm5);
        decoded.regD   = lowReg(instr.regFmt.regD);
        decoded.regA   = lowReg(instr.regFmt.regA);
      end

      4'd1: begin
        decoded.regD = lowReg(instr.regFmt.regD);
        decoded.regA = lowReg(instr.regFmt.regA);
        if (!instr.regFmt.op) begin // ASR immediate
          decoded.id     = 7'h03;
          decoded.offset = zext5(instr.regFmt.imm5);
        end else begin
          case (instr.regFmt.imm5[4:3])
            2'd0: begin // ADD register
              decoded.id   = 7'h04;
              decoded.regB = lowReg(instr.regFmt.imm5[2:0]);
            end
            2'd1: begin // SUB register
              decoded.id   = 7'h05;
              decoded.regB = lowReg(instr.regFmt.imm5[2:0]);
            end
            2'd2: begin // ADD 3-bit immediate
              decoded.id     = 7'h06;
              decoded.offset = zext5({2'b00, instr.regFmt.imm5[2:0]});
            end
            2'd3: begin // SUB 3-bit immediate
              decoded.id     = 7'h07;
              decoded.offset = zext5({2'b00, instr.regFmt.imm5[2:0]});
            end
            default: decoded.id = idUndefAddSub;
          endcase
        end
      end

      4'd2, 4'd3: begin // MOV/CMP and ADD/SUB with imm8
        if (instr.immFmt.opcode[0])
          decoded.id = instr.immFmt.op ? 7'h0b : 7'h0a;
        else
          decoded.id = instr.immFmt.op ? 7'h09 : 7'h08;
        decoded.offset = zext8(instr.immFmt.imm8);
        decoded.regD   = lowReg(instr.immFmt.regIdx);
        decoded.regA   = lowReg(instr.immFmt.regIdx);
      end

      4'd4: begin
        if (instr.immFmt.op) begin // PC-relative load
          decoded.id     = 7'h27;
          decoded.offset = zext8(instr.immFmt.imm8);
          decoded.regD   = lowReg(instr.immFmt.regIdx);
          decoded.regA   = 4'hf;
          decoded.regB   = lowReg(instr.immFmt.regIdx);
        end else begin
          decoded.regD = lowReg(instr.regFmt.regD);
          decoded.regA = lowReg(instr.regFmt.regD);
          decoded.regB = lowReg(instr.regFmt.regA);
          case (funct2[2:0])
            3'd0, 3'd1, 3'd2, 3'd3: begin // ALU ops, four per group from 0x0c
              decoded.id = 7'h0c + {3'd0, funct2[1:0], funct1};
            end
            3'd4: begin // High-register ADD
              case (funct1)
                2'd1: begin
                  decoded.id      = 7'h1c;
                  decoded.regB[3] = 1'b1;
                end
                2'd2: begin
                  decoded.id      = 7'h1d;
                  decoded.regD[3] = 1'b1;
                  decoded.regA[3] = 1'b1;
                end
                2'd3: begin
                  decoded.id      = 7'h1e;
                  decoded.regD[3] = 1'b1;
                  decoded.regA[3] = 1'b1;
                  decoded.regB[3] = 1'b1;
                end
                default: decoded.id = 7'h0c;
              endcase
            end
            3'd5: begin // High-register CMP
              case (funct1)
                2'd1: begin
                  decoded.id      = 7'h1f;
                  decoded.regB[3] = 1'b1;
                end
                2'd2: begin
                  decoded.id      = 7'h20;
                  decoded.regD[3] = 1'b1;
                  decoded.regA[3] = 1'b1;
                end
                2'd3: begin
                  decoded.id      = 7'h21;
                  decoded.regD[3] = 1'b1;
                  decoded.regA[3] = 1'b1;
                end
                default: decoded.id = 7'h0c;
              endcase
            end
            3'd6: begin // High-register MOV
              decoded.id      = 7'h22 + {5'd0, funct1};
              decoded.regD[3] = funct1[1];
              decoded.regA[3] = funct1[1];
              decoded.regB[3] = funct1[0];
            end
            3'd7: begin // BX, condition in bits 7..4
              decoded.branchCond = {1'b0, instr.immFmt.imm8[7:4]};
              decoded.id   = (instr.immFmt.imm8[7:4] == 4'hf) ? 7'h4c : 7'h26;
              decoded.regA = 4'hf;
              decoded.regB = lowReg(instr.regFmt.regD);
            end
            default: decoded.id = idUndefAlu;
          endcase
        end
      end

      4'd5: begin // Register-offset load/store, eight forms
        decoded.id   = 7'h28 + {4'd0, instr.regFmt.op, instr.regFmt.imm5[4:3]};
        decoded.regD = lowReg(instr.regFmt.regD);
        decoded.regA = lowReg(instr.regFmt.regA);
        decoded.regB = lowReg(instr.regFmt.imm5[2:0]);
      end

      4'd6, 4'd7, 4'd8: begin
        // Immediate-offset load/store, IDs 0x30 to 0x35 in opcode order
        decoded.id     = 7'h24 + {2'd0, instr.regFmt.opcode, instr.regFmt.op};
        decoded.regD   = lowReg(instr.regFmt.regD);
        decoded.regA   = lowReg(instr.regFmt.regA);
        decoded.offset = zext5(instr.regFmt.imm5);
      end

      4'd9: begin // SP-relative load/store
        decoded.id     = instr.immFmt.op ? 7'h37 : 7'h36;
        decoded.offset = zext8(instr.immFmt.imm8);
        decoded.regD   = lowReg(instr.immFmt.regIdx);
        decoded.regA   = 4'he;
      end

      4'd10: begin // Address from PC or SP
        decoded.id     = instr.immFmt.op ? 7'h39 : 7'h38;
        decoded.offset = zext8(instr.immFmt.imm8);
        decoded.regD   = lowReg(instr.immFmt.regIdx);
        decoded.regA   = instr.immFmt.op ? 4'he : 4'hf;
      end

      4'd11: begin
        case (funct2)
          4'd0: decoded.id = 7'h3a; // SP adjust
          4'd2, 4'd10: begin // Extend and reverse groups
            decoded.id   = (funct2[3] ? 7'h3f : 7'h3b) + {5'd0, funct1};
            decoded.regD = lowReg(instr.regFmt.regD);
            decoded.regB = lowReg(instr.regFmt.regA);
          end
          4'd4: begin
            decoded.id   = 7'h43;
            decoded.regD = lowReg(instr.regFmt.regD);
          end
          4'd13: begin
            decoded.id   = 7'h44;
            decoded.regD = lowReg(instr.regFmt.regD);
          end
          4'd14: begin
            case (funct1)
              2'd0: begin // OUTPUT
                decoded.id   = 7'h45;
                decoded.regD = lowReg(instr.regFmt.regD);
              end
              2'd1: decoded.id = 7'h46; // PAUSE
              2'd2: begin // INPUT
                decoded.id   = 7'h47;
                decoded.regD = lowReg(instr.regFmt.regD);
              end
              default: decoded.id = idUndefMisc;
            endcase
          end
          default: decoded.id = idUndefMisc;
        endcase
      end

      4'd12: begin // SWI
        decoded.id         = 7'h48;
        decoded.offset     = 12'd9; // Handler address
        decoded.regB       = 4'hd;  // Link register
        decoded.branchCond = condAlways;
      end

      4'd13: begin // Conditional branch
        decoded.id         = 7'h49;
        decoded.branchCond = {1'b0, instr.immFmt.op, instr.immFmt.regIdx};
        decoded.offset     = zext8(instr.immFmt.imm8);
        decoded.regA       = 4'hf;
      end

      4'd14: begin
        decoded.id = instr.immFmt.op ? idNop : idHlt;
        if (instr.immFmt.op && isBios) begin // NOP in BIOS jumps to user code
          decoded.id         = idBiosJump;
          decoded.branchCond = condBiosJump;
          decoded.offset     = 12'd2048;
          decoded.regA       = 4'hf;
        end
      end

      4'd15: begin
        decoded.id = (instr == {`INSTR_WIDTH{1'b1}}) ? idResetMarker : idUndefOpcode;
      end

      default: decoded.id = idUndefOpcode;
    endcase
  end

endmodule

`default_nettype wire

// File: src/flagUnit.sv
`timescale 1ns/1ps
`default_nettype none

module flagUnit (
  input  wire                   clk,
  input  wire                   rstN,
  input  wire                   flagWe,
  input  wire decodePkg::flagsT flagIn,
  output logic [15:0]           condTrue
);

  import decodePkg::*;

  flagsT flags;
  logic  signedGe; // N equals V

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else if (flagWe) begin
      flags <= flagIn;
    end
  end

  assign signedGe = (flags.n == flags.v);

  // One bit per condition code, independent of the instruction
  always_comb begin
    condTrue[0]  = flags.z;                  // EQ
    condTrue[1]  = ~flags.z;                 // NE
    condTrue[2]  = flags.c;                  // CS
    condTrue[3]  = ~flags.c;                 // CC
    condTrue[4]  = flags.n;                  // MI
    condTrue[5]  = ~flags.n;                 // PL
    condTrue[6]  = flags.v;                  // VS
    condTrue[7]  = ~flags.v;                 // VC
    condTrue[8]  = flags.c & ~flags.z;       // HI
    condTrue[9]  = ~flags.c | flags.z;       // LS
    condTrue[10] = signedGe;                 // GE
    condTrue[11] = ~signedGe;                // LT
    condTrue[12] = ~flags.z & signedGe;      // GT
    condTrue[13] = flags.z | ~signedGe;      // LE
    condTrue[14] = 1'b1;                     // AL
    condTrue[15] = 1'b1;                     // BIOS jump and BX always
  end

endmodule

`default_nettype wire

// File: src/issueCombiner.sv
`timescale 1ns/1ps
`default_nettype none

module issueCombiner (
  input  wire                     clk,
  input  wire                     rstN,
  input  wire decodePkg::decodedT decoded,
  input  wire [15:0]              condTrue,
  input  wire                     instrValid,
  output decodePkg::issueT        issue,
  output logic                    issueValid
);

  logic branchTaken;

  // Codes 16 and up are never taken
  assign branchTaken = ~decoded.branchCond[4] & condTrue[decoded.branchCond[3:0]];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      issueValid <= 1'b0;
    end else begin
      issueValid <= instrValid;
    end
  end

  // Bundle holds its last value while idle
  always_ff @(posedge clk) begin
    if (instrValid) begin
      issue.decoded     <= decoded;
      issue.branchTaken <= branchTaken;
    end
  end

endmodule

`default_nettype wire

// File: src/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
  input  wire                    clk,
  input  wire                    rstN,
  input  wire isaPkg::instrWordT instr,
  input  wire                    instrValid,
  input  wire                    isBios,
  input  wire                    flagWe,
  input  wire decodePkg::flagsT  flagIn,
  output decodePkg::issueT       issue,
  output logic                   issueValid
);

  import decodePkg::*;

  decodedT     decoded;
  logic [15:0] condTrue; // Evaluated in parallel with decode

  instructionDecoder instructionDecoder_inst (
    .instr   (instr),
    .isBios  (isBios),
    .decoded (decoded)
  );

  flagUnit flagUnit_inst (
    .clk      (clk),
    .rstN     (rstN),
    .flagWe   (flagWe),
    .flagIn   (flagIn),
    .condTrue (condTrue)
  );

  issueCombiner issueCombiner_inst (
    .clk        (clk),
    .rstN       (rstN),
    .decoded    (decoded),
    .condTrue   (condTrue),
    .instrValid (instrValid),
    .issue      (issue),
    .issueValid (issueValid)
  );

endmodule

`default_nettype wire

// File: tb/decodeChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module decodeChecker (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [`INSTR_WIDTH-1:0] instr,
  input  logic                    instrValid,
  input  logic                    isBios,
  input  logic                    flagWe,
  input  decodePkg::flagsT        flagIn,
  input  decodePkg::issueT        issue,
  input  logic                    issueValid,
  output int                      mismatchCount,
  output int                      protocolCount,
  output int                      bundleCount,
  output int                      pendingCount
);

  import decodePkg::*;

  flagsT                   modelFlags; // Mirror of the NZCV register
  issueT                   expectQ[$];
  logic [`INSTR_WIDTH-1:0] wordQ[$];   // Source word of each bundle, for error lines
  int                      mismatches = 0;
  int                      protoErrors = 0;
  int                      bundles = 0;
  int                      pending = 0;

  logic                    sampledRstN;
  logic                    sampledValid;
  logic [`INSTR_WIDTH-1:0] sampledInstr;
  logic                    sampledBios;
  logic                    sampledWe;
  flagsT                   sampledFlags;

  assign mismatchCount = mismatches;
  assign protocolCount = protoErrors;
  assign bundleCount   = bundles;
  assign pendingCount  = pending;

  // ARM condition rules, 15 is always and 16 up is not a branch
  function automatic logic condHolds(input flagsT f, input logic [4:0] code);
    logic r;
    case (code)
      5'd0:  r = f.z;
      5'd1:  r = !f.z;
      5'd2:  r = f.c;
      5'd3:  r = !f.c;
      5'd4:  r = f.n;
      5'd5:  r = !f.n;
      5'd6:  r = f.v;
      5'd7:  r = !f.v;
      5'd8:  r = f.c && !f.z;
      5'd9:  r = !f.c || f.z;
      5'd10: r = (f.n == f.v);
      5'd11: r = (f.n != f.v);
      5'd12: r = !f.z && (f.n == f.v);
      5'd13: r = f.z || (f.n != f.v);
      5'd14, 5'd15: r = 1'b1;
      default: r = 1'b0;
    endcase
    return r;
  endfunction

  // Reference decode straight from the raw bit positions
  function automatic decodedT refDecode(input logic [15:0] w, input logic bios);
    decodedT d;
    logic [3:0] lo;  // Bits 2..0
    logic [3:0] mid; // Bits 5..3
    logic [3:0] hi;  // Bits 10..8
    lo  = {1'b0, w[2:0]};
    mid = {1'b0, w[5:3]};
    hi  = {1'b0, w[10:8]};
    d   = '0;
    d.branchCond = 5'd31;
    case (w[15:12])
      4'h0, 4'h1: begin
        d.regD = lo;
        d.regA = mid;
        if (w[12] && w[11]) begin // Three-operand add/sub
          d.id = 7'h04 + {5'd0, w[10:9]};
          if (w[10])
            d.offset = {9'd0, w[8:6]};
          else
            d.regB = {1'b0, w[8:6]};
        end else begin
          d.id     = 7'h01 + {5'd0, w[12], w[11]};
          d.offset = {7'd0, w[10:6]};
        end
      end
      4'h2, 4'h3: begin
        d.id     = 7'h08 + {5'd0, w[12], w[11]};
        d.offset = {4'd0, w[7:0]};
        d.regD   = hi;
        d.regA   = hi;
      end
      4'h4: begin
        if (w[11]) begin // Literal load
          d.id     = 7'h27;
          d.offset = {4'd0, w[7:0]};
          d.regD   = hi;
          d.regA   = 4'hf;
          d.regB   = hi;
        end else begin
          d.regD = lo;
          d.regA = lo;
          d.regB = mid;
          if (!w[10]) begin
            d.id = 7'h0c + {3'd0, w[9:6]};
          end else if (w[9:8] == 2'd3) begin // BX
            d.id         = (w[7:4] == 4'hf) ? 7'h4c : 7'h26;
            d.branchCond = {1'b0, w[7:4]};
            d.regA       = 4'hf;
            d.regB       = lo;
          end else if (w[9:8] == 2'd2) begin
            d.id      = 7'h22 + {5'd0, w[7:6]};
            d.regD[3] = w[7];
            d.regA[3] = w[7];
            d.regB[3] = w[6];
          end else if (w[7:6] == 2'd0) begin
            d.id = 7'h0c;
          end else begin // High ADD or CMP
            d.id      = (w[8] ? 7'h1e : 7'h1b) + {5'd0, w[7:6]};
            d.regD[3] = w[7];
            d.regA[3] = w[7];
            d.regB[3] = w[6] && !(w[8] && w[7]);
          end
        end
      end
      4'h5: begin
        d.id   = 7'h28 + {4'd0, w[11:9]};
        d.regD = lo;
        d.regA = mid;
        d.regB = {1'b0, w[8:6]};
      end
      4'h6, 4'h7, 4'h8: begin
        if (w[15:12] == 4'h6)
          d.id = 7'h30;
        else if (w[15:12] == 4'h7)
          d.id = 7'h32;
        else
          d.id = 7'h34;
        d.id     = d.id | {6'd0, w[11]};
        d.regD   = lo;
        d.regA   = mid;
        d.offset = {7'd0, w[10:6]};
      end
      4'h9, 4'ha: begin
        d.id     = ((w[15:12] == 4'h9) ? 7'h36 : 7'h38) | {6'd0, w[11]};
        d.offset = {4'd0, w[7:0]};
        d.regD   = hi;
        d.regA   = (w[15:12] == 4'ha && !w[11]) ? 4'hf : 4'he;
      end
      4'hb: begin
        case (w[11:8])
          4'd0: d.id = 7'h3a;
          4'd2, 4'd10: begin
            d.id   = (w[11] ? 7'h3f : 7'h3b) + {5'd0, w[7:6]};
            d.regD = lo;
            d.regB = mid;
          end
          4'd4: begin
            d.id   = 7'h43;
            d.regD = lo;
          end
          4'd13: begin
            d.id   = 7'h44;
            d.regD = lo;
          end
          4'd14: begin // OUTPUT, PAUSE, INPUT
            d.id = (w[7:6] == 2'd3) ? 7'h7a : 7'h45 + {5'd0, w[7:6]};
            if (w[7:6] == 2'd0 || w[7:6] == 2'd2)
              d.regD = lo;
          end
          default: d.id = 7'h7a;
        endcase
      end
      4'hc: begin // SWI
        d.id         = 7'h48;
        d.offset     = 12'd9;
        d.regB       = 4'hd;
        d.branchCond = 5'd14;
      end
      4'hd: begin
        d.id         = 7'h49;
        d.branchCond = {1'b0, w[11:8]};
        d.offset     = {4'd0, w[7:0]};
        d.regA       = 4'hf;
      end
      4'he: begin
        if (w[11] && bios) begin
          d.id         = 7'd77;
          d.branchCond = 5'd15;
          d.offset     = 12'd2048;
          d.regA       = 4'hf;
        end else begin
          d.id = w[11] ? 7'h4b : 7'h4a;
        end
      end
      default: d.id = (&w) ? 7'd100 : 7'h7f;
    endcase
    return d;
  endfunction

  task automatic checkField(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal, input logic [15:0] word);
    if (expVal !== actVal) begin
      $display("error %s: expected 0x%0h actual 0x%0h (instr 0x%04h at %0t)",
               name, expVal, actVal, word, $time);
      mismatches++;
    end
  endtask

  task automatic compareBundle(input issueT e, input logic [15:0] word);
    checkField("decode id", 32'(e.decoded.id), 32'(issue.decoded.id), word);
    checkField("decode regD", 32'(e.decoded.regD), 32'(issue.decoded.regD), word);
    checkField("decode regA", 32'(e.decoded.regA), 32'(issue.decoded.regA), word);
    checkField("decode regB", 32'(e.decoded.regB), 32'(issue.decoded.regB), word);
    checkField("decode offset", 32'(e.decoded.offset), 32'(issue.decoded.offset), word);
    checkField("decode branchCond", 32'(e.decoded.branchCond),
               32'(issue.decoded.branchCond), word);
    checkField("branch taken", 32'(e.branchTaken), 32'(issue.branchTaken), word);
  endtask

  // Inputs are stable at the rising edge
  always @(posedge clk) begin
    sampledRstN  <= rstN;
    sampledValid <= instrValid;
    sampledInstr <= instr;
    sampledBios  <= isBios;
    sampledWe    <= flagWe;
    sampledFlags <= flagIn;
  end

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    issueT expected;
    logic [15:0] word;
    if (!sampledRstN) begin
      modelFlags = '0;
      expectQ.delete();
      wordQ.delete();
    end else begin
      if (sampledValid) begin
        expected.decoded     = refDecode(sampledInstr, sampledBios);
        expected.branchTaken = condHolds(modelFlags, expected.decoded.branchCond);
        expectQ.push_back(expected);
        wordQ.push_back(sampledInstr);
      end
      if (sampledWe)
        modelFlags = sampledFlags; // Seen from the next instruction on
      if (issueValid === 1'b1) begin
        if (expectQ.size() == 0) begin
          $display("issueValid is high with no instruction outstanding at %0t", $time);
          protoErrors++;
        end else begin
          expected = expectQ.pop_front();
          word     = wordQ.pop_front();
          compareBundle(expected, word);
          bundles++;
        end
      end else if (expectQ.size() != 0) begin
        $display("no bundle issued one cycle after instrValid at %0t", $time);
        protoErrors++;
        void'(expectQ.pop_front());
        void'(wordQ.pop_front());
      end
    end
    pending = expectQ.size();
  end

endmodule

`default_nettype wire

// File: tb/decodeStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStageTb;

  import isaPkg::*;
  import decodePkg::*;

  localparam int resetCycles    = 8;
  localparam int directedCycles = 12;
  localparam int numInstr       = 2000;
  localparam int stimCycleMax   = 2 * numInstr; // Valid density is about 3/4
  localparam int marginCycles   = 100;
  localparam int clkPeriod      = 8;
  localparam int directedValid  = 5;

  logic        clk;
  logic        rstN;
  instrWordT   instr;
  logic        instrValid;
  logic        isBios;
  logic        flagWe;
  flagsT       flagIn;
  issueT       issue;
  logic        issueValid;
  logic [31:0] lfsr;
  int          validSent;
  int          mismatchCount;
  int          protocolCount;
  int          bundleCount;
  int          pendingCount;

  decodeStage decodeStage_inst (
    .clk        (clk),
    .rstN       (rstN),
    .instr      (instr),
    .instrValid (instrValid),
    .isBios     (isBios),
    .flagWe     (flagWe),
    .flagIn     (flagIn),
    .issue      (issue),
    .issueValid (issueValid)
  );

  decodeChecker decodeChecker_inst (
    .clk           (clk),
    .rstN          (rstN),
    .instr         (instr),
    .instrValid    (instrValid),
    .isBios        (isBios),
    .flagWe        (flagWe),
    .flagIn        (flagIn),
    .issue         (issue),
    .issueValid    (issueValid),
    .mismatchCount (mismatchCount),
    .protocolCount (protocolCount),
    .bundleCount   (bundleCount),
    .pendingCount  (pendingCount)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] stepLfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic takeBits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = stepLfsr(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  task automatic driveCycle(input logic [15:0] word, input logic valid, input logic bios,
                            input logic we, input logic [3:0] flags);
    @(negedge clk);
    instr      = word;
    instrValid = valid;
    isBios     = bios;
    flagWe     = we;
    flagIn     = flags;
  endtask

  task automatic randomCycle();
    logic [31:0] r;
    logic [15:0] word;
    logic        valid;
    logic        bios;
    logic        we;
    logic [3:0]  flags;
    takeBits(2, r);
    valid = (r[1:0] != 2'd0);
    takeBits(16, r);
    word = r[15:0];
    takeBits(3, r);
    if (r[2:0] == 3'd0) begin // Force opcodes 12 to 15
      takeBits(2, r);
      word[15:12] = {2'b11, r[1:0]};
    end else if (r[2:0] == 3'd1) begin
      word = 16'hffff;
    end
    takeBits(1, r);
    bios = r[0];
    takeBits(2, r);
    we = (r[1:0] == 2'd0);
    takeBits(4, r);
    flags = r[3:0];
    driveCycle(word, valid, bios, we, flags);
    if (valid)
      validSent++;
  endtask

  initial begin
    rstN       = 1'b0;
    instr      = '0;
    instrValid = 1'b0;
    isBios     = 1'b0;
    flagWe     = 1'b0;
    flagIn     = '0;
    lfsr       = 32'h14a3;
    validSent  = 0;
    repeat (resetCycles) @(posedge clk); // Rising edges seen with reset low
    @(negedge clk);
    rstN = 1'b1;
    repeat (3) driveCycle(16'h0000, 1'b0, 1'b0, 1'b0, 4'h0); // Idle after reset
    driveCycle(16'he800, 1'b1, 1'b1, 1'b0, 4'h0); // NOP in BIOS
    driveCycle(16'he800, 1'b1, 1'b0, 1'b0, 4'h0); // Plain NOP
    driveCycle(16'hd010, 1'b1, 1'b0, 1'b1, 4'b0100); // BEQ while Z is written
    driveCycle(16'hd010, 1'b1, 1'b0, 1'b0, 4'h0);    // BEQ sees Z now
    driveCycle(16'hd110, 1'b1, 1'b0, 1'b0, 4'h0);    // BNE
    driveCycle(16'h0000, 1'b0, 1'b0, 1'b0, 4'h0);
    while (validSent < numInstr)
      randomCycle();
    repeat (3) driveCycle(16'h0000, 1'b0, 1'b0, 1'b0, 4'h0); // Drain
    @(posedge clk); // Counts only move on falling edges
    if (pendingCount != 0)
      $display("%0d expected bundles were never issued", pendingCount);
    if (bundleCount != numInstr + directedValid)
      $display("expected %0d bundles but %0d were checked", numInstr + directedValid,
               bundleCount);
    $display("bundles %0d, value errors %0d, protocol errors %0d, left in queue %0d",
             bundleCount, mismatchCount, protocolCount, pendingCount);
    if (mismatchCount == 0 && protocolCount == 0 && pendingCount == 0
        && bundleCount == numInstr + directedValid) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #((resetCycles + directedCycles + stimCycleMax + marginCycles) * clkPeriod);
    $display("watchdog expired before the stimulus finished");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+common
common/isaPkg.sv
common/decodePkg.sv
decoder/instructionDecoder.sv
src/flagUnit.sv
src/issueCombiner.sv
src/decodeStage.sv
tb/decodeChecker.sv
tb/decodeStageTb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := decodeStageTb
RTL_TOP    := decodeStage
FILELIST   := list.f
BUILD_DIR  := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --top-module $(RTL_TOP)
PASS_MSG   := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
